// ==== vlog.f ====
ooo_pkg.sv
inst_decoder.sv
map_table.sv
arch_regfile.sv
reorder_buffer.sv
reservation_station.sv
function_units.sv
ooo_core.sv
tb_ooo_core.sv

// ==== tb_ooo_core.sv ====
`default_nettype none

module tb_ooo_core;

    localparam int n_inst         = 300;
    localparam int alu_only       = 40;  // first block, no multiplies
    localparam int mul_end        = 80;  // multiply-only block ends here
    localparam int timeout_cycles = n_inst * 20;

    logic        clock;
    logic        reset;
    logic        inst_valid;
    logic [31:0] inst;
    logic        stall;
    logic        commit_valid;
    logic [4:0]  commit_idx;
    logic [31:0] commit_data;

    logic [31:0] lfsr;
    logic [31:0] model_regs [32]; // in-order reference state
    logic [4:0]  exp_idx_q  [$];
    logic [31:0] exp_data_q [$];
    int          issued;          // words presented, held ones counted once
    int          accepted;
    int          commits;
    int          checks;
    int          errors;
    logic        accept_now;      // set at negedge, used by the driver
    logic        stall_seen;
    logic        drain;

    always #10 clock = ~clock;

    ooo_core #(.rob_depth(8), .rs_depth(4)) u_dut (
        .clock(clock), .reset(reset), .inst_valid(inst_valid), .inst(inst),
        .stall(stall), .commit_valid(commit_valid), .commit_idx(commit_idx),
        .commit_data(commit_data)
    );

    //////////////////////////////
    // random source
    //////////////////////////////
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr); // one step per bit
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // k: 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 mul 7 addi 8 andi 9 ori 10 xori 11 slti
    function automatic logic [31:0] make_inst(input int n);
        int          k;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic [6:0]  f7;
        if (n >= alu_only && n < mul_end) begin
            k   = 6;
            rd  = 5'd1 + 5'(take_bits(1)); // x1/x2 only, long dependent chains
            rs1 = 5'd1 + 5'(take_bits(1));
            rs2 = 5'd1 + 5'(take_bits(1));
        end else begin
            if (n < alu_only) begin
                k = int'(take_bits(4) % 11);
                if (k >= 6) k++; // skip mul
            end else begin
                k = int'(take_bits(4) % 12);
            end
            rd  = 5'(take_bits(3)); // x0..x7, dense reuse
            rs1 = 5'(take_bits(3));
            rs2 = 5'(take_bits(3));
        end
        imm = 12'(take_bits(12));
        case (k)
            2, 8:    f3 = 3'b111;
            3, 9:    f3 = 3'b110;
            4, 10:   f3 = 3'b100;
            5, 11:   f3 = 3'b010;
            default: f3 = 3'b000; // add sub mul addi
        endcase
        f7 = (k == 1) ? 7'b0100000 : (k == 6) ? 7'b0000001 : 7'b0000000;
        if (k < 7) return {f7, rs2, rs1, f3, rd, 7'b0110011};
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // reference result straight from the rv32 encoding
    function automatic logic [31:0] model_result(input logic [31:0] w);
        logic        is_imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        is_imm = (w[6:0] == 7'b0010011);
        a      = model_regs[w[19:15]];
        b      = is_imm ? {{20{w[31]}}, w[31:20]} : model_regs[w[24:20]];
        case (w[14:12])
            3'b111:  r = a & b;
            3'b110:  r = a | b;
            3'b100:  r = a ^ b;
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: begin
                if (!is_imm && w[31:25] == 7'b0100000) r = a - b;
                else if (!is_imm && w[31:25] == 7'b0000001) r = a * b; // low word
                else r = a + b;
            end
        endcase
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    //////////////////////////////
    // monitor, mid-cycle sampling
    //////////////////////////////
    always @(negedge clock) begin : monitor
        logic [31:0] result;
        accept_now = 1'b0;
        if (!reset) begin
            if (stall && accepted >= alu_only && accepted < mul_end) begin // mul word held
                stall_seen = 1'b1;
            end
            if (commit_valid) begin // older than anything accepted this cycle
                commits++;
                if (exp_idx_q.size() == 0) begin
                    errors++;
                    $display("commit %0d arrived with no accepted instruction left", commits);
                end else begin
                    check_value($sformatf("commit %0d index", commits),
                                {27'd0, exp_idx_q.pop_front()}, {27'd0, commit_idx});
                    check_value($sformatf("commit %0d data", commits),
                                exp_data_q.pop_front(), commit_data);
                end
            end
            if (inst_valid && !stall) begin // taken at the coming edge
                accept_now = 1'b1;
                accepted++;
                result = model_result(inst);
                exp_idx_q.push_back(inst[11:7]);
                exp_data_q.push_back(result);
                if (inst[11:7] != 5'd0) model_regs[inst[11:7]] = result; // x0 stays zero
            end
        end
    end

    initial begin
        clock      = 1'b0;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        lfsr       = 32'he3de1afb;
        issued     = 0;
        accepted   = 0;
        commits    = 0;
        checks     = 0;
        errors     = 0;
        accept_now = 1'b0;
        stall_seen = 1'b0;
        drain      = 1'b0;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("after reset stall", 32'd0, {31'd0, stall});
        check_value("after reset commit_valid", 32'd0, {31'd0, commit_valid});

        // hold the word while stalled, new word once taken or idle
        while (!drain) begin
            @(posedge clock);
            if (!inst_valid || accept_now) begin
                if (issued == n_inst) begin
                    inst_valid <= 1'b0;
                    drain = 1'b1;
                end else if ((issued >= alu_only && issued < mul_end) ||
                             take_bits(2) != 0) begin // mul block runs back to back
                    inst       <= make_inst(issued);
                    inst_valid <= 1'b1;
                    issued++;
                end else begin
                    inst_valid <= 1'b0;
                end
            end
        end

        while (commits < n_inst) @(negedge clock);
        repeat (20) @(negedge clock); // extra commits would show up here
        check_value("commit count", 32'(accepted), 32'(commits));
        check_value("outstanding entries", 32'd0, 32'(exp_idx_q.size()));
        if (!stall_seen) begin
            errors++;
            $display("stall never rose during the multiply run");
        end
        $display("checks %0d errors %0d accepted %0d commits %0d",
                 checks, errors, accepted, commits);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clock);
        $display("timeout after %0d cycles, %0d of %0d instructions committed",
                 timeout_cycles, commits, n_inst);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ooo_core.sv ====
`default_nettype none

module ooo_core import ooo_pkg::*; #(
    parameter  int rob_depth = 8,
    parameter  int rs_depth  = 4,
    localparam int tag_w     = $clog2(rob_depth)
) (
    input  wire               clock,
    input  wire               reset,
    input  wire               inst_valid,
    input  wire [31:0]        inst,
    output logic              stall,
    output logic              commit_valid,
    output reg_idx_t          commit_idx,
    output logic [xlen-1:0]   commit_data
);

    logic             dispatch;
    reg_idx_t         dec_rs1;
    reg_idx_t         dec_rs2;
    reg_idx_t         dec_rd;
    logic [xlen-1:0]  dec_imm;
    logic             dec_use_imm;
    logic             dec_is_mul;
    alu_op_e          dec_alu_op;

    logic             rs1_busy;
    logic             rs2_busy;
    logic [tag_w-1:0] rs1_tag;
    logic [tag_w-1:0] rs2_tag;
    logic [xlen-1:0]  rs1_value;
    logic [xlen-1:0]  rs2_value;
    logic             query_done1;
    logic             query_done2;
    logic [xlen-1:0]  query_value1;
    logic [xlen-1:0]  query_value2;

    logic [tag_w-1:0] tail_tag;
    logic             rob_full;
    logic             rs_full;
    logic             retire;
    reg_idx_t         retire_rd;
    logic [tag_w-1:0] retire_tag;
    logic [xlen-1:0]  retire_value;

    logic             issue;
    logic             issue_mul;
    alu_op_e          issue_op;
    logic [xlen-1:0]  issue_a;
    logic [xlen-1:0]  issue_b;
    logic [tag_w-1:0] issue_tag;
    logic             alu_ready;
    logic             cdb_valid;
    logic [tag_w-1:0] cdb_tag;
    logic [xlen-1:0]  cdb_value;

    assign stall    = rob_full || rs_full; // level, source holds inst
    assign dispatch = inst_valid && !stall;

    inst_decoder u_decoder (
        .inst(inst), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd), .imm(dec_imm),
        .use_imm(dec_use_imm), .is_mul(dec_is_mul), .alu_op(dec_alu_op)
    );

    map_table #(.rob_depth(rob_depth)) u_map (
        .clock(clock), .reset(reset), .rs1(dec_rs1), .rs2(dec_rs2),
        .rs1_busy(rs1_busy), .rs1_tag(rs1_tag), .rs2_busy(rs2_busy), .rs2_tag(rs2_tag),
        .dispatch(dispatch), .dispatch_rd(dec_rd), .dispatch_tag(tail_tag),
        .retire(retire), .retire_rd(retire_rd), .retire_tag(retire_tag)
    );

    arch_regfile u_regfile (
        .clock(clock), .reset(reset), .rs1(dec_rs1), .rs2(dec_rs2),
        .rs1_value(rs1_value), .rs2_value(rs2_value),
        .write(retire), .write_idx(retire_rd), .write_value(retire_value)
    );

    reorder_buffer #(.rob_depth(rob_depth)) u_rob (
        .clock(clock), .reset(reset), .dispatch(dispatch), .dispatch_rd(dec_rd),
        .tail_tag(tail_tag), .rob_full(rob_full),
        .query_tag1(rs1_tag), .query_tag2(rs2_tag),
        .query_done1(query_done1), .query_value1(query_value1),
        .query_done2(query_done2), .query_value2(query_value2),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .retire(retire), .retire_rd(retire_rd), .retire_tag(retire_tag),
        .retire_value(retire_value)
    );

    reservation_station #(.rob_depth(rob_depth), .rs_depth(rs_depth)) u_rs (
        .clock(clock), .reset(reset), .dispatch(dispatch), .alu_op(dec_alu_op),
        .is_mul(dec_is_mul), .use_imm(dec_use_imm), .imm(dec_imm), .dest_tag(tail_tag),
        .rs1_busy(rs1_busy), .rs1_tag(rs1_tag), .rs1_value(rs1_value),
        .query_done1(query_done1), .query_value1(query_value1),
        .rs2_busy(rs2_busy), .rs2_tag(rs2_tag), .rs2_value(rs2_value),
        .query_done2(query_done2), .query_value2(query_value2),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .alu_ready(alu_ready), .rs_full(rs_full),
        .issue(issue), .issue_mul(issue_mul), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b), .issue_tag(issue_tag)
    );

    function_units #(.rob_depth(rob_depth)) u_fu (
        .clock(clock), .reset(reset), .issue(issue), .issue_mul(issue_mul),
        .issue_op(issue_op), .issue_a(issue_a), .issue_b(issue_b), .issue_tag(issue_tag),
        .alu_ready(alu_ready), .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
        .cdb_value(cdb_value)
    );

    // retirement is the commit
    assign commit_valid = retire;
    assign commit_idx   = retire_rd;
    assign commit_data  = retire_value;

endmodule

`default_nettype wire

// ==== function_units.sv ====
`default_nettype none

module function_units import ooo_pkg::*; #(
    parameter  int rob_depth = 8,
    localparam int tag_w     = $clog2(rob_depth)
) (
    input  wire                   clock,
    input  wire                   reset,
    input  wire                   issue,
    input  wire                   issue_mul,
    input  wire alu_op_e          issue_op,
    input  wire [xlen-1:0]        issue_a,
    input  wire [xlen-1:0]        issue_b,
    input  wire [tag_w-1:0]       issue_tag,
    output logic                  alu_ready,
    output logic                  cdb_valid,
    output logic [tag_w-1:0]      cdb_tag,
    output logic [xlen-1:0]       cdb_value
);

    logic [xlen-1:0]  alu_result;
    logic             alu_v;  // alu output register holds a result
    logic [tag_w-1:0] alu_tag;
    logic [xlen-1:0]  alu_val;

    logic [2:0]       mul_v;        // one bit per stage
    logic [tag_w-1:0] mul_tag [3];
    logic [xlen-1:0]  mul_a;
    logic [xlen-1:0]  mul_b;
    logic [xlen-1:0]  mul_p1;       // low half of product
    logic [xlen-1:0]  mul_p2;

    //////////////////////////////
    // single cycle alu
    //////////////////////////////
    always_comb begin
        case (issue_op)
            alu_sub: alu_result = issue_a - issue_b;
            alu_and: alu_result = issue_a & issue_b;
            alu_or:  alu_result = issue_a | issue_b;
            alu_xor: alu_result = issue_a ^ issue_b;
            alu_slt: alu_result = {{(xlen - 1){1'b0}}, $signed(issue_a) < $signed(issue_b)};
            default: alu_result = issue_a + issue_b; // add
        endcase
    end

    assign alu_ready = !(alu_v && mul_v[2]); // lost the bus, hold

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_v <= 1'b0;
            mul_v <= '0;
        end else begin
            if (alu_ready) alu_v <= issue && !issue_mul;
            mul_v <= {mul_v[1:0], issue && issue_mul};
        end
    end

    always_ff @(posedge clock) begin
        if (alu_ready) begin
            alu_tag <= issue_tag;
            alu_val <= alu_result;
        end
        mul_a      <= issue_a;  // stage 1 operands
        mul_b      <= issue_b;
        mul_tag[0] <= issue_tag;
        mul_p1     <= mul_a * mul_b; // stage 2, truncated to xlen
        mul_tag[1] <= mul_tag[0];
        mul_p2     <= mul_p1;   // stage 3
        mul_tag[2] <= mul_tag[1];
    end

    // multiplier output first, it cannot stall
    assign cdb_valid = mul_v[2] || alu_v;
    assign cdb_tag   = mul_v[2] ? mul_tag[2] : alu_tag;
    assign cdb_value = mul_v[2] ? mul_p2 : alu_val;

endmodule

`default_nettype wire

// ==== reservation_station.sv ====
`default_nettype none

module reservation_station import ooo_pkg::*; #(
    parameter  int rob_depth = 8,
    parameter  int rs_depth  = 4,
    localparam int tag_w     = $clog2(rob_depth),
    localparam int idx_w     = $clog2(rs_depth)
) (
    input  wire                   clock,
    input  wire                   reset,
    input  wire                   dispatch,
    input  wire alu_op_e          alu_op,
    input  wire                   is_mul,
    input  wire                   use_imm,
    input  wire [xlen-1:0]        imm,
    input  wire [tag_w-1:0]       dest_tag,
    input  wire                   rs1_busy,
    input  wire [tag_w-1:0]       rs1_tag,
    input  wire [xlen-1:0]        rs1_value,
    input  wire                   query_done1,
    input  wire [xlen-1:0]        query_value1,
    input  wire                   rs2_busy,
    input  wire [tag_w-1:0]       rs2_tag,
    input  wire [xlen-1:0]        rs2_value,
    input  wire                   query_done2,
    input  wire [xlen-1:0]        query_value2,
    input  wire                   cdb_valid,
    input  wire [tag_w-1:0]       cdb_tag,
    input  wire [xlen-1:0]        cdb_value,
    input  wire                   alu_ready,
    output logic                  rs_full,
    output logic                  issue,
    output logic                  issue_mul,
    output alu_op_e               issue_op,
    output logic [xlen-1:0]       issue_a,
    output logic [xlen-1:0]       issue_b,
    output logic [tag_w-1:0]      issue_tag
);

    logic [rs_depth-1:0] ent_valid;
    logic [rs_depth-1:0] ent_mul;
    logic [rs_depth-1:0] a_rdy;
    logic [rs_depth-1:0] b_rdy;
    alu_op_e             ent_op [rs_depth];
    logic [xlen-1:0]     a_val  [rs_depth];
    logic [xlen-1:0]     b_val  [rs_depth];
    logic [tag_w-1:0]    a_tag  [rs_depth];
    logic [tag_w-1:0]    b_tag  [rs_depth];
    logic [tag_w-1:0]    dest   [rs_depth];

    logic [xlen:0]       src_a;    // {ready, value}
    logic [xlen:0]       src_b;
    logic [rs_depth-1:0] ready;
    logic [idx_w-1:0]    free_idx;
    logic [idx_w-1:0]    pick;

    // regfile, then finished rob entry, then this cycle's bus, else wait
    function automatic logic [xlen:0] resolve(
        input logic            busy,
        input logic [tag_w-1:0] tag,
        input logic [xlen-1:0]  reg_value,
        input logic            done,
        input logic [xlen-1:0]  rob_value
    );
        if (!busy) return {1'b1, reg_value};
        if (done) return {1'b1, rob_value};
        if (cdb_valid && cdb_tag == tag) return {1'b1, cdb_value};
        return {1'b0, reg_value};
    endfunction

    always_comb begin
        src_a = resolve(rs1_busy, rs1_tag, rs1_value, query_done1, query_value1);
        src_b = use_imm ? {1'b1, imm}
                        : resolve(rs2_busy, rs2_tag, rs2_value, query_done2, query_value2);
    end

    assign rs_full = &ent_valid;
    // alu entries wait while the alu result is held off the bus
    assign ready   = ent_valid & a_rdy & b_rdy & (ent_mul | {rs_depth{alu_ready}});

    // descending scan so the lowest index wins
    always_comb begin
        free_idx = '0;
        pick     = '0;
        issue    = 1'b0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!ent_valid[i]) free_idx = idx_w'(i);
            if (ready[i]) begin
                issue = 1'b1;
                pick  = idx_w'(i);
            end
        end
    end

    assign issue_mul = ent_mul[pick];
    assign issue_op  = ent_op[pick];
    assign issue_a   = a_val[pick];
    assign issue_b   = b_val[pick];
    assign issue_tag = dest[pick];

    always_ff @(posedge clock) begin
        if (reset) begin
            ent_valid <= '0;
        end else begin
            for (int i = 0; i < rs_depth; i++) begin // bus snoop
                if (cdb_valid && ent_valid[i] && !a_rdy[i] && a_tag[i] == cdb_tag) begin
                    a_val[i] <= cdb_value;
                    a_rdy[i] <= 1'b1;
                end
                if (cdb_valid && ent_valid[i] && !b_rdy[i] && b_tag[i] == cdb_tag) begin
                    b_val[i] <= cdb_value;
                    b_rdy[i] <= 1'b1;
                end
            end
            if (issue) ent_valid[pick] <= 1'b0;
            if (dispatch) begin // free slot differs from pick
                ent_valid[free_idx] <= 1'b1;
                ent_mul[free_idx]   <= is_mul;
                ent_op[free_idx]    <= alu_op;
                a_rdy[free_idx]     <= src_a[xlen];
                a_val[free_idx]     <= src_a[xlen-1:0];
                a_tag[free_idx]     <= rs1_tag;
                b_rdy[free_idx]     <= src_b[xlen];
                b_val[free_idx]     <= src_b[xlen-1:0];
                b_tag[free_idx]     <= rs2_tag;
                dest[free_idx]      <= dest_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== reorder_buffer.sv ====
`default_nettype none

module reorder_buffer import ooo_pkg::*; #(
    parameter  int rob_depth = 8,
    localparam int tag_w     = $clog2(rob_depth)
) (
    input  wire                   clock,
    input  wire                   reset,
    input  wire                   dispatch,
    input  wire reg_idx_t         dispatch_rd,
    output logic [tag_w-1:0]      tail_tag,
    output logic                  rob_full,
    input  wire [tag_w-1:0]       query_tag1,
    input  wire [tag_w-1:0]       query_tag2,
    output logic                  query_done1,
    output logic [xlen-1:0]       query_value1,
    output logic                  query_done2,
    output logic [xlen-1:0]       query_value2,
    input  wire                   cdb_valid,
    input  wire [tag_w-1:0]       cdb_tag,
    input  wire [xlen-1:0]        cdb_value,
    output logic                  retire,
    output reg_idx_t              retire_rd,
    output logic [tag_w-1:0]      retire_tag,
    output logic [xlen-1:0]       retire_value
);

    reg_idx_t             ent_rd    [rob_depth];
    logic [xlen-1:0]      ent_value [rob_depth];
    logic [rob_depth-1:0] ent_done;

    logic [tag_w-1:0] head;  // oldest
    logic [tag_w-1:0] tail;  // next free
    logic [tag_w:0]   count; // one extra bit to tell full from empty

    // circular increment, depth need not be a power of two
    function automatic logic [tag_w-1:0] next_ptr(input logic [tag_w-1:0] p);
        return (p == tag_w'(rob_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign tail_tag = tail; // new tag is the slot index
    assign rob_full = (count == (tag_w + 1)'(rob_depth));

    //////////////////////////////
    // operand lookup for dispatch
    //////////////////////////////
    assign query_done1  = ent_done[query_tag1];
    assign query_value1 = ent_value[query_tag1];
    assign query_done2  = ent_done[query_tag2];
    assign query_value2 = ent_value[query_tag2];

    //////////////////////////////
    // retire from head
    //////////////////////////////
    assign retire       = (count != '0) && ent_done[head];
    assign retire_rd    = ent_rd[head];
    assign retire_tag   = head;
    assign retire_value = ent_value[head];

    always_ff @(posedge clock) begin
        if (reset) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            ent_done <= '0;
        end else begin
            if (dispatch) begin
                ent_rd[tail]   <= dispatch_rd;
                ent_done[tail] <= 1'b0;
                tail           <= next_ptr(tail);
            end
            if (cdb_valid) begin // never hits the free tail slot
                ent_done[cdb_tag]  <= 1'b1;
                ent_value[cdb_tag] <= cdb_value;
            end
            if (retire) begin
                head <= next_ptr(head);
            end
            case ({dispatch, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== arch_regfile.sv ====
`default_nettype none

module arch_regfile import ooo_pkg::*; (
    input  wire                   clock,
    input  wire                   reset,
    input  wire reg_idx_t         rs1,
    input  wire reg_idx_t         rs2,
    output logic [xlen-1:0]       rs1_value,
    output logic [xlen-1:0]       rs2_value,
    input  wire                   write,
    input  wire reg_idx_t         write_idx,
    input  wire [xlen-1:0]        write_value
);

    logic [xlen-1:0] regs [32];

    // x0 reads zero whatever is stored
    assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0; // clean architectural state
            end
        end else if (write && write_idx != '0) begin
            regs[write_idx] <= write_value; // in-order retire write
        end
    end

endmodule

`default_nettype wire

// ==== map_table.sv ====
`default_nettype none

module map_table import ooo_pkg::*; #(
    parameter  int rob_depth = 8,
    localparam int tag_w     = $clog2(rob_depth)
) (
    input  wire                    clock,
    input  wire                    reset,
    input  wire reg_idx_t          rs1,
    input  wire reg_idx_t          rs2,
    output logic                   rs1_busy,
    output logic [tag_w-1:0]       rs1_tag,
    output logic                   rs2_busy,
    output logic [tag_w-1:0]       rs2_tag,
    input  wire                    dispatch,
    input  wire reg_idx_t          dispatch_rd,
    input  wire [tag_w-1:0]        dispatch_tag,
    input  wire                    retire,
    input  wire reg_idx_t          retire_rd,
    input  wire [tag_w-1:0]        retire_tag
);

    logic [31:0]      busy;     // result still in flight
    logic [tag_w-1:0] tag [32]; // rob entry of youngest writer

    assign rs1_busy = busy[rs1];
    assign rs1_tag  = tag[rs1];
    assign rs2_busy = busy[rs2];
    assign rs2_tag  = tag[rs2];

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
        end else begin
            // only the youngest writer frees the register
            if (retire && tag[retire_rd] == retire_tag) begin
                busy[retire_rd] <= 1'b0;
            end
            if (dispatch && dispatch_rd != '0) begin // x0 stays ready
                busy[dispatch_rd] <= 1'b1; // overrides same-cycle retire
                tag[dispatch_rd]  <= dispatch_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== inst_decoder.sv ====
`default_nettype none

module inst_decoder import ooo_pkg::*; (
    input  wire inst_word_u  inst,
    output reg_idx_t         rs1,
    output reg_idx_t         rs2,
    output reg_idx_t         rd,
    output logic [xlen-1:0]  imm,
    output logic             use_imm,
    output logic             is_mul,
    output alu_op_e          alu_op
);

    logic [2:0] f3; // funct3 from whichever view applies

    assign use_imm = (inst.r_fields.opcode == op_imm);
    assign is_mul  = (alu_op == alu_mul);

    always_comb begin
        rs2 = '0; // i-type has no rs2, x0 is never busy
        imm = '0;
        if (use_imm) begin
            rs1 = inst.i_fields.rs1;
            rd  = inst.i_fields.rd;
            f3  = inst.i_fields.funct3;
            imm = {{(xlen - 12){inst.i_fields.imm[11]}}, inst.i_fields.imm}; // sign extend
        end else begin
            rs1 = inst.r_fields.rs1;
            rs2 = inst.r_fields.rs2;
            rd  = inst.r_fields.rd;
            f3  = inst.r_fields.funct3;
        end

        alu_op = alu_add;
        case (f3)
            f3_add: begin
                if (!use_imm) begin // funct7 only means something on r-type
                    case (inst.r_fields.funct7)
                        f7_base: alu_op = alu_add;
                        f7_sub:  alu_op = alu_sub;
                        f7_mul:  alu_op = alu_mul;
                        default: alu_op = alu_add;
                    endcase
                end
            end
            f3_slt:  alu_op = alu_slt;
            f3_xor:  alu_op = alu_xor;
            f3_or:   alu_op = alu_or;
            f3_and:  alu_op = alu_and;
            default: alu_op = alu_add; // unsupported
        endcase
    end

endmodule

`default_nettype wire

// ==== ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    localparam int xlen = 32; // rv32 data path

    typedef logic [4:0] reg_idx_t; // x0..x31

    // alu operation, mul steers to the multiplier
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_mul
    } alu_op_e;

    //////////////////////////////
    // opcode and function codes
    //////////////////////////////
    localparam logic [6:0] op_reg = 7'b0110011; // r-type alu
    localparam logic [6:0] op_imm = 7'b0010011; // i-type alu

    localparam logic [2:0] f3_add = 3'b000; // shared by sub and mul
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;
    localparam logic [6:0] f7_mul  = 7'b0000001; // m extension

    // same 32 bits, read as r-type or i-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } r_fields;
        struct packed {
            logic [11:0] imm;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } i_fields;
    } inst_word_u;

endpackage

`default_nettype wire
